// ==== ooo_pkg.sv ====
////////////////////////////////////////
// ooo back end shared definitions
// widths, function codes, operand word
////////////////////////////////////////

package ooo_pkg;

	////////////////////////////////////////
	// widths
	////////////////////////////////////////
	localparam int XLEN     = 64;                          // data path width
	localparam int PRF_SIZE = 64;                          // physical registers
	localparam int TAG_W    = $clog2(PRF_SIZE);            // 6 bit tag

	localparam int N_UNITS  = 3;                           // cdb requesters
	localparam int MULT_IDX = 0;                           // highest priority, drains first
	localparam int ALU1_IDX = 1;
	localparam int ALU2_IDX = 2;

	typedef logic [TAG_W-1:0] tag_t;                       // physical register tag
	typedef logic [XLEN-1:0]  data_t;                      // data word

	// ALU_MUL is steered to the multiplier, everything else to an alu
	typedef enum logic [2:0] {
		ALU_ADD = 3'd0,
		ALU_SUB = 3'd1,
		ALU_AND = 3'd2,
		ALU_OR  = 3'd3,
		ALU_XOR = 3'd4,
		ALU_MUL = 3'd5
	} alu_func_t;

	////////////////////////////////////////
	// operand word
	////////////////////////////////////////
	typedef struct packed {
		logic [XLEN-TAG_W-1:0] pad;                        // zero when carrying a tag
		tag_t                  tag;                        // producer tag in low bits
	} operand_tag_t;

	// one word, two readings: value when its ready flag is set, tag otherwise
	typedef union packed {
		data_t        value;
		operand_tag_t tag;
	} operand_t;

endpackage

// ==== rs.sv ====
////////////////////////////////////////
// reservation station
// holds renamed ops, snoops the cdb, issues oldest first
////////////////////////////////////////
`timescale 1ns/1ns

module rs import ooo_pkg::*; #(
	parameter int RS_DEPTH = 8                             // number of entries
) (
	input  logic      clock,
	input  logic      rst_n,
	// dispatch
	input  logic      dispatch_valid,                      // ignored while rs_full
	input  alu_func_t dispatch_func,
	input  tag_t      dispatch_dest,
	input  operand_t  dispatch_opa,
	input  logic      dispatch_opa_ready,                  // 1 means opa holds a value
	input  operand_t  dispatch_opb,
	input  logic      dispatch_opb_ready,
	output logic      rs_full,
	// cdb snoop
	input  logic      cdb_valid,
	input  tag_t      cdb_tag,
	input  data_t     cdb_value,
	// unit availability
	input  logic      mult_accept,
	input  logic      alu1_accept,
	input  logic      alu2_accept,
	// issue to multiplier
	output logic      mult_issue,
	output data_t     mult_opa,
	output data_t     mult_opb,
	output tag_t      mult_dest,
	// issue to alu1
	output logic      alu1_issue,
	output data_t     alu1_opa,
	output data_t     alu1_opb,
	output alu_func_t alu1_func,
	output tag_t      alu1_dest,
	// issue to alu2
	output logic      alu2_issue,
	output data_t     alu2_opa,
	output data_t     alu2_opb,
	output alu_func_t alu2_func,
	output tag_t      alu2_dest
);

	localparam int IDX_W = (RS_DEPTH > 1) ? $clog2(RS_DEPTH) : 1;

	typedef logic [RS_DEPTH-1:0] mask_t;

	////////////////////////////////////////
	// entry state
	////////////////////////////////////////
	mask_t                     entry_valid;
	mask_t                     entry_opa_ready;
	mask_t                     entry_opb_ready;
	logic [RS_DEPTH-1:0][RS_DEPTH-1:0] older;              // older[j][i]: j came before i
	alu_func_t                 entry_func [RS_DEPTH];
	tag_t                      entry_dest [RS_DEPTH];
	operand_t                  entry_opa  [RS_DEPTH];
	operand_t                  entry_opb  [RS_DEPTH];

	mask_t      wake_a, wake_b;                            // cdb tag hits on waiting operands
	mask_t      mul_cand, alu_cand;                        // fully ready, split by kind
	mask_t      alu_first, alu_second;
	mask_t      mult_sel, alu1_sel, alu2_sel, issue_mask;
	logic [IDX_W-1:0] free_idx;
	logic       do_dispatch;
	logic       disp_a_hit, disp_b_hit;

	// one-hot of the candidate that no other candidate is older than
	function automatic mask_t pick_oldest(input mask_t cand,
		input logic [RS_DEPTH-1:0][RS_DEPTH-1:0] age);
		mask_t sel;
		sel = '0;
		for (int i = 0; i < RS_DEPTH; i++) begin
			sel[i] = cand[i];
			for (int j = 0; j < RS_DEPTH; j++)
				if (cand[j] && age[j][i])
					sel[i] = 1'b0;                         // someone older is ready
		end
		return sel;
	endfunction

	assign rs_full     = &entry_valid;
	assign do_dispatch = dispatch_valid && !rs_full;
	assign disp_a_hit  = cdb_valid && !dispatch_opa_ready && (dispatch_opa.tag.tag == cdb_tag);
	assign disp_b_hit  = cdb_valid && !dispatch_opb_ready && (dispatch_opb.tag.tag == cdb_tag);

	always_comb begin
		free_idx = '0;
		for (int i = RS_DEPTH - 1; i >= 0; i--)
			if (!entry_valid[i])
				free_idx = IDX_W'(i);                      // lowest free slot wins
		for (int i = 0; i < RS_DEPTH; i++) begin
			wake_a[i]   = cdb_valid && entry_valid[i] && !entry_opa_ready[i] &&
				(entry_opa[i].tag.tag == cdb_tag);
			wake_b[i]   = cdb_valid && entry_valid[i] && !entry_opb_ready[i] &&
				(entry_opb[i].tag.tag == cdb_tag);
			mul_cand[i] = entry_valid[i] && entry_opa_ready[i] && entry_opb_ready[i] &&
				(entry_func[i] == ALU_MUL);
			alu_cand[i] = entry_valid[i] && entry_opa_ready[i] && entry_opb_ready[i] &&
				(entry_func[i] != ALU_MUL);
		end
	end

	////////////////////////////////////////
	// select
	////////////////////////////////////////
	assign alu_first  = pick_oldest(alu_cand, older);
	assign alu_second = pick_oldest(alu_cand & ~alu_first, older);
	assign mult_sel   = mult_accept ? pick_oldest(mul_cand, older) : '0;
	assign alu1_sel   = alu1_accept ? alu_first : '0;
	assign alu2_sel   = !alu2_accept ? '0 : (alu1_accept ? alu_second : alu_first);
	assign issue_mask = mult_sel | alu1_sel | alu2_sel;

	assign mult_issue = |mult_sel;
	assign alu1_issue = |alu1_sel;
	assign alu2_issue = |alu2_sel;

	always_comb begin
		mult_opa  = '0;
		mult_opb  = '0;
		mult_dest = '0;
		alu1_opa  = '0;
		alu1_opb  = '0;
		alu1_func = ALU_ADD;
		alu1_dest = '0;
		alu2_opa  = '0;
		alu2_opb  = '0;
		alu2_func = ALU_ADD;
		alu2_dest = '0;
		for (int i = 0; i < RS_DEPTH; i++) begin
			if (mult_sel[i]) begin
				mult_opa  = entry_opa[i].value;
				mult_opb  = entry_opb[i].value;
				mult_dest = entry_dest[i];
			end
			if (alu1_sel[i]) begin
				alu1_opa  = entry_opa[i].value;
				alu1_opb  = entry_opb[i].value;
				alu1_func = entry_func[i];
				alu1_dest = entry_dest[i];
			end
			if (alu2_sel[i]) begin
				alu2_opa  = entry_opa[i].value;
				alu2_opb  = entry_opb[i].value;
				alu2_func = entry_func[i];
				alu2_dest = entry_dest[i];
			end
		end
	end

	////////////////////////////////////////
	// update
	////////////////////////////////////////
	always_ff @(posedge clock or negedge rst_n) begin
		if (!rst_n) begin
			entry_valid     <= '0;
			entry_opa_ready <= '0;
			entry_opb_ready <= '0;
			older           <= '0;
		end else begin
			for (int i = 0; i < RS_DEPTH; i++) begin
				if (issue_mask[i])
					entry_valid[i] <= 1'b0;                // freed on issue
				if (wake_a[i])
					entry_opa_ready[i] <= 1'b1;
				if (wake_b[i])
					entry_opb_ready[i] <= 1'b1;
			end
			if (do_dispatch) begin
				entry_valid[free_idx]     <= 1'b1;
				entry_opa_ready[free_idx] <= dispatch_opa_ready || disp_a_hit;
				entry_opb_ready[free_idx] <= dispatch_opb_ready || disp_b_hit;
				for (int j = 0; j < RS_DEPTH; j++) begin
					older[free_idx][j] <= 1'b0;            // newest, older than nobody
					older[j][free_idx] <= entry_valid[j];  // every live entry beats it
				end
			end
		end
	end

	always_ff @(posedge clock) begin
		for (int i = 0; i < RS_DEPTH; i++) begin
			if (wake_a[i])
				entry_opa[i].value <= cdb_value;           // tag view replaced by value
			if (wake_b[i])
				entry_opb[i].value <= cdb_value;
		end
		if (do_dispatch) begin
			entry_func[free_idx]      <= dispatch_func;
			entry_dest[free_idx]      <= dispatch_dest;
			entry_opa[free_idx].value <= disp_a_hit ? cdb_value : dispatch_opa.value;
			entry_opb[free_idx].value <= disp_b_hit ? cdb_value : dispatch_opb.value;
		end
	end

endmodule

// ==== alu_unit.sv ====
////////////////////////////////////////
// single cycle alu
// result held in place until the cdb grants it
////////////////////////////////////////
`timescale 1ns/1ns

module alu_unit import ooo_pkg::*; (
	input  logic      clock,
	input  logic      rst_n,
	input  logic      issue,                               // strobe from rs
	input  data_t     opa,
	input  data_t     opb,
	input  alu_func_t func,
	input  tag_t      dest,
	input  logic      grant,                               // from cdb arbiter
	output logic      accept,                              // free or draining this cycle
	output logic      req,                                 // result waiting for the bus
	output data_t     result,
	output tag_t      result_tag
);

	data_t alu_out;
	logic  take;

	always_comb begin
		case (func)
			ALU_ADD: alu_out = opa + opb;
			ALU_SUB: alu_out = opa - opb;
			ALU_AND: alu_out = opa & opb;
			ALU_OR:  alu_out = opa | opb;
			ALU_XOR: alu_out = opa ^ opb;
			default: alu_out = '0;                         // mul never steered here
		endcase
	end

	assign accept = !req || grant;                         // slot frees in the grant cycle
	assign take   = issue && accept;

	always_ff @(posedge clock or negedge rst_n) begin
		if (!rst_n)
			req <= 1'b0;
		else if (take)
			req <= 1'b1;                                   // back to back when granted
		else if (grant)
			req <= 1'b0;
	end

	// holding register, cdb reads straight from here
	always_ff @(posedge clock) begin
		if (take) begin
			result     <= alu_out;
			result_tag <= dest;
		end
	end

endmodule

// ==== mult_unit.sv ====
////////////////////////////////////////
// pipelined 64 bit multiplier
// one operand slice per stage, low word of product
////////////////////////////////////////
`timescale 1ns/1ns

module mult_unit import ooo_pkg::*; #(
	parameter int MULT_STAGES = 4                          // latency in cycles
) (
	input  logic  clock,
	input  logic  rst_n,
	input  logic  issue,
	input  data_t opa,
	input  data_t opb,
	input  tag_t  dest,
	input  logic  grant,
	output logic  accept,                                  // same as pipe advance
	output logic  req,
	output data_t result,
	output tag_t  result_tag
);

	localparam int    LAST       = MULT_STAGES - 1;
	localparam int    CHUNK      = (XLEN + MULT_STAGES - 1) / MULT_STAGES; // opb bits per stage
	localparam data_t CHUNK_MASK = {XLEN{1'b1}} >> (XLEN - CHUNK);

	logic [MULT_STAGES-1:0] stage_valid;
	tag_t                   stage_tag  [MULT_STAGES];
	data_t                  stage_a    [MULT_STAGES];     // multiplicand, pre-shifted
	data_t                  stage_b    [MULT_STAGES];     // multiplier, slices left to do
	data_t                  stage_prod [MULT_STAGES];     // running partial product
	logic                   advance;

	// one slice worth of partial product
	function automatic data_t part(input data_t a, input data_t b);
		return a * (b & CHUNK_MASK);
	endfunction

	assign advance    = !(stage_valid[LAST] && !grant);   // freeze whole pipe when blocked
	assign accept     = advance;
	assign req        = stage_valid[LAST];
	assign result     = stage_prod[LAST];
	assign result_tag = stage_tag[LAST];

	always_ff @(posedge clock or negedge rst_n) begin
		if (!rst_n)
			stage_valid <= '0;
		else if (advance) begin
			stage_valid[0] <= issue;
			for (int k = 1; k < MULT_STAGES; k++)
				stage_valid[k] <= stage_valid[k-1];
		end
	end

	always_ff @(posedge clock) begin
		if (advance) begin
			stage_tag[0]  <= dest;
			stage_prod[0] <= part(opa, opb);               // lowest slice
			stage_a[0]    <= opa << CHUNK;
			stage_b[0]    <= opb >> CHUNK;
			for (int k = 1; k < MULT_STAGES; k++) begin
				stage_tag[k]  <= stage_tag[k-1];
				stage_prod[k] <= stage_prod[k-1] + part(stage_a[k-1], stage_b[k-1]);
				stage_a[k]    <= stage_a[k-1] << CHUNK;
				stage_b[k]    <= stage_b[k-1] >> CHUNK;
			end
		end
	end

endmodule

// ==== cdb_arbiter.sv ====
////////////////////////////////////////
// cdb arbiter
// fixed priority grant, muxes winner onto the bus
////////////////////////////////////////
`timescale 1ns/1ns

module cdb_arbiter import ooo_pkg::*; (
	input  logic                       [N_UNITS-1:0] req,        // held until granted
	input  data_t                      [N_UNITS-1:0] result,
	input  tag_t                       [N_UNITS-1:0] result_tag,
	output logic                       [N_UNITS-1:0] grant,      // one hot
	output logic                                     cdb_valid,
	output tag_t                                     cdb_tag,
	output data_t                                    cdb_value
);

	// lowest index wins, multiplier sits at index 0
	always_comb begin
		logic found;
		found     = 1'b0;
		grant     = '0;
		cdb_tag   = '0;
		cdb_value = '0;
		for (int i = 0; i < N_UNITS; i++) begin
			if (req[i] && !found) begin
				found     = 1'b1;
				grant[i]  = 1'b1;
				cdb_tag   = result_tag[i];
				cdb_value = result[i];
			end
		end
	end

	assign cdb_valid = |req;                               // someone always wins

endmodule

// ==== ooo_core.sv ====
////////////////////////////////////////
// ooo back end top
// rs, mult, two alus and the cdb arbiter
////////////////////////////////////////
`timescale 1ns/1ns

module ooo_core import ooo_pkg::*; #(
	parameter int RS_DEPTH    = 8,
	parameter int MULT_STAGES = 4
) (
	input  logic      clock,
	input  logic      rst_n,
	input  logic      dispatch_valid,
	input  alu_func_t dispatch_func,
	input  tag_t      dispatch_dest,
	input  operand_t  dispatch_opa,
	input  logic      dispatch_opa_ready,
	input  operand_t  dispatch_opb,
	input  logic      dispatch_opb_ready,
	output logic      rs_full,
	output logic      cdb_valid,
	output tag_t      cdb_tag,
	output data_t     cdb_value
);

	////////////////////////////////////////
	// rs to units
	////////////////////////////////////////
	logic      mult_issue, alu1_issue, alu2_issue;
	logic      mult_accept, alu1_accept, alu2_accept;
	data_t     mult_opa, mult_opb, alu1_opa, alu1_opb, alu2_opa, alu2_opb;
	alu_func_t alu1_func, alu2_func;
	tag_t      mult_dest, alu1_dest, alu2_dest;

	// units to arbiter, indexed by requester
	logic  [N_UNITS-1:0] unit_req;
	logic  [N_UNITS-1:0] unit_grant;
	data_t [N_UNITS-1:0] unit_result;
	tag_t  [N_UNITS-1:0] unit_tag;

	rs #(.RS_DEPTH(RS_DEPTH)) u_rs (
		.clock, .rst_n,
		.dispatch_valid, .dispatch_func, .dispatch_dest,
		.dispatch_opa, .dispatch_opa_ready, .dispatch_opb, .dispatch_opb_ready,
		.rs_full,
		.cdb_valid, .cdb_tag, .cdb_value,                  // wake-up loop
		.mult_accept, .alu1_accept, .alu2_accept,
		.mult_issue, .mult_opa, .mult_opb, .mult_dest,
		.alu1_issue, .alu1_opa, .alu1_opb, .alu1_func, .alu1_dest,
		.alu2_issue, .alu2_opa, .alu2_opb, .alu2_func, .alu2_dest
	);

	mult_unit #(.MULT_STAGES(MULT_STAGES)) u_mult (
		.clock, .rst_n,
		.issue(mult_issue), .opa(mult_opa), .opb(mult_opb), .dest(mult_dest),
		.grant(unit_grant[MULT_IDX]), .accept(mult_accept),
		.req(unit_req[MULT_IDX]), .result(unit_result[MULT_IDX]),
		.result_tag(unit_tag[MULT_IDX])
	);

	alu_unit alu1 (
		.clock, .rst_n,
		.issue(alu1_issue), .opa(alu1_opa), .opb(alu1_opb), .func(alu1_func),
		.dest(alu1_dest), .grant(unit_grant[ALU1_IDX]), .accept(alu1_accept),
		.req(unit_req[ALU1_IDX]), .result(unit_result[ALU1_IDX]),
		.result_tag(unit_tag[ALU1_IDX])
	);

	alu_unit alu2 (
		.clock, .rst_n,
		.issue(alu2_issue), .opa(alu2_opa), .opb(alu2_opb), .func(alu2_func),
		.dest(alu2_dest), .grant(unit_grant[ALU2_IDX]), .accept(alu2_accept),
		.req(unit_req[ALU2_IDX]), .result(unit_result[ALU2_IDX]),
		.result_tag(unit_tag[ALU2_IDX])
	);

	cdb_arbiter u_cdb (
		.req(unit_req), .result(unit_result), .result_tag(unit_tag),
		.grant(unit_grant),
		.cdb_valid, .cdb_tag, .cdb_value                   // also the core outputs
	);

endmodule

// ==== tb_ooo_core.sv ====
////////////////////////////////////////
// ooo back end testbench
// tag indexed scoreboard, checks every cdb result
////////////////////////////////////////
`timescale 1ns/1ns

module tb_ooo_core import ooo_pkg::*; ();

	localparam int RS_DEPTH    = 8;
	localparam int MULT_STAGES = 4;
	localparam int TIMEOUT     = 500;                      // cycles allowed per wait

	logic      clock, rst_n, dispatch_valid, dispatch_opa_ready, dispatch_opb_ready;
	alu_func_t dispatch_func;
	tag_t      dispatch_dest;
	operand_t  dispatch_opa, dispatch_opb;
	logic      rs_full, cdb_valid;
	tag_t      cdb_tag;
	data_t     cdb_value;

	data_t  exp_value [PRF_SIZE];                          // planned result per tag
	logic   pending   [PRF_SIZE];                          // dispatched, not yet broadcast
	logic   reserved  [PRF_SIZE];                          // producer planned, not dispatched
	tag_t   recent    [8];                                 // last dests, feed dependencies
	int     n_pending, hist_cnt, i;
	integer seed;
	tag_t   tag_ptr, prev, dest, prod;
	logic   a_dep, b_dep;

	ooo_core #(.RS_DEPTH(RS_DEPTH), .MULT_STAGES(MULT_STAGES)) DUT (.*);

	initial begin
		clock = 1'b0;
		forever #5 clock = ~clock;                         // 10 ns period
	end

	task automatic report_failure(input string msg);
		$display("%s", msg);
		$display("TEST FAILED");
		$fatal(1, "run stopped at the first error");
	endtask

	task automatic check_level(input string name, input logic got, input logic want);
		assert (got === want)
			else report_failure($sformatf("mismatch at %0t: %s got %b expected %b",
				$time, name, got, want));
	endtask

	// reference rule for every function code
	function automatic data_t apply_op(input alu_func_t f, input data_t a, input data_t b);
		case (f)
			ALU_ADD: return a + b;
			ALU_SUB: return a - b;
			ALU_AND: return a & b;
			ALU_OR:  return a | b;
			ALU_XOR: return a ^ b;
			ALU_MUL: return a * b;                         // low word only
			default: return '0;
		endcase
	endfunction

	function automatic data_t rand_data();
		return {$random(seed), $random(seed)};
	endfunction

	function automatic alu_func_t rand_func(input int n_codes);
		return alu_func_t'(3'({$random(seed)} % n_codes));
	endfunction

	function automatic operand_t make_operand(input logic as_tag, input tag_t t, input data_t v);
		operand_t op;
		op = '0;
		if (as_tag)
			op.tag.tag = t;                                // pad stays zero
		else
			op.value = v;
		return op;
	endfunction

	task automatic alloc_tag(output tag_t t);
		tag_t cand;
		cand = tag_ptr;
		for (int n = 0; n < PRF_SIZE; n++) begin
			cand = tag_t'(cand + 1);                       // round robin, spreads reuse
			if (!pending[cand] && !reserved[cand]) begin
				tag_ptr = cand;
				t = cand;
				return;
			end
		end
		report_failure("no free tag left to allocate");
	endtask

	// called at a falling edge, returns one falling edge later
	task automatic dispatch_op(input alu_func_t f, input tag_t d, input logic a_is_tag,
		input data_t a, input logic b_is_tag, input data_t b);
		tag_t a_tag, b_tag;
		logic a_wait, b_wait;
		int   waited;
		waited = 0;
		while (rs_full) begin
			@(negedge clock);
			waited++;
			if (waited > TIMEOUT)
				report_failure("rs_full stayed high and the dispatch could not proceed");
		end
		a_tag  = tag_t'(a);
		b_tag  = tag_t'(b);
		a_wait = a_is_tag && (pending[a_tag] || reserved[a_tag]);
		b_wait = b_is_tag && (pending[b_tag] || reserved[b_tag]);
		if (a_is_tag)
			a = exp_value[a_tag];                          // producer value, known or planned
		if (b_is_tag)
			b = exp_value[b_tag];
		dispatch_valid     = 1'b1;
		dispatch_func      = f;
		dispatch_dest      = d;
		dispatch_opa       = make_operand(a_wait, a_tag, a);
		dispatch_opa_ready = !a_wait;
		dispatch_opb       = make_operand(b_wait, b_tag, b);
		dispatch_opb_ready = !b_wait;
		exp_value[d] = apply_op(f, a, b);
		pending[d]   = 1'b1;
		reserved[d]  = 1'b0;
		n_pending++;
		@(negedge clock);
		dispatch_valid = 1'b0;
	endtask

	task automatic wait_for_tag(input tag_t t);
		int waited;
		waited = 0;
		while (!(cdb_valid && cdb_tag == t)) begin
			@(negedge clock);
			waited++;
			if (waited > TIMEOUT || !pending[t])
				report_failure($sformatf("tag %0d never showed up on the cdb", t));
		end
	endtask

	task automatic wait_drain();
		int waited;
		waited = 0;
		while (n_pending != 0) begin
			@(negedge clock);
			waited++;
			if (waited > TIMEOUT)
				report_failure($sformatf("%0d results never reached the cdb", n_pending));
		end
	endtask

	////////////////////////////////////////
	// cdb monitor
	////////////////////////////////////////
	always @(posedge clock) begin
		if (rst_n) begin
			assert (!(dispatch_valid && rs_full))
				else report_failure("dispatch was strobed while rs_full was high");
			if (cdb_valid) begin
				assert (pending[cdb_tag])
					else report_failure($sformatf("tag %0d on the cdb at %0t was not pending",
						cdb_tag, $time));
				assert (cdb_value === exp_value[cdb_tag])
					else report_failure($sformatf("mismatch at %0t: cdb_value got %h expected %h",
						$time, cdb_value, exp_value[cdb_tag]));
				pending[cdb_tag] = 1'b0;                   // tag free for reuse
				n_pending--;
			end
		end
	end

	initial begin
		seed = 96;
		rst_n = 1'b0;
		dispatch_valid = 1'b0;
		dispatch_func = ALU_ADD;
		dispatch_dest = '0;
		dispatch_opa = '0;
		dispatch_opb = '0;
		dispatch_opa_ready = 1'b1;
		dispatch_opb_ready = 1'b1;
		for (i = 0; i < PRF_SIZE; i++) begin
			pending[i] = 1'b0;
			reserved[i] = 1'b0;
			exp_value[i] = '0;
		end
		n_pending = 0;
		hist_cnt = 0;
		tag_ptr = '0;
		repeat (2) @(posedge clock);
		@(negedge clock);
		rst_n = 1'b1;
		for (i = 0; i < 10; i++) begin                     // idle after reset
			check_level("cdb_valid", cdb_valid, 1'b0);
			check_level("rs_full", rs_full, 1'b0);
			@(negedge clock);
		end
		for (i = 0; i < 20; i++) begin                     // independent alu ops
			alloc_tag(dest);
			dispatch_op(rand_func(5), dest, 1'b0, rand_data(), 1'b0, rand_data());
		end
		wait_drain();
		alloc_tag(prev);                                   // back to back chain
		dispatch_op(ALU_ADD, prev, 1'b0, rand_data(), 1'b0, rand_data());
		for (i = 0; i < 8; i++) begin
			alloc_tag(dest);
			dispatch_op(rand_func(6), dest, 1'b1, data_t'(prev), 1'b0, rand_data());
			prev = dest;
		end
		for (i = 0; i < 6; i++) begin                      // dispatch during producer broadcast
			wait_for_tag(prev);
			alloc_tag(dest);
			dispatch_op(ALU_SUB, dest, 1'b1, data_t'(prev), 1'b0, rand_data());
			prev = dest;
		end
		wait_drain();
		for (i = 0; i < 12; i++) begin                     // multiplies with alu traffic
			alloc_tag(dest);
			dispatch_op((i % 3 == 2) ? ALU_OR : ALU_MUL, dest, 1'b0, rand_data(),
				1'b0, rand_data());
		end
		wait_drain();
		alloc_tag(prod);                                   // producer planned, held back
		reserved[prod] = 1'b1;
		exp_value[prod] = apply_op(ALU_ADD, 64'h1234, 64'h4321);
		for (i = 0; i < RS_DEPTH - 1; i++) begin
			alloc_tag(dest);
			dispatch_op(rand_func(6), dest, 1'b1, data_t'(prod), i[0], data_t'(prod));
		end
		for (i = 0; i < 10; i++) begin
			check_level("cdb_valid", cdb_valid, 1'b0);
			@(negedge clock);
		end
		dispatch_op(ALU_ADD, prod, 1'b0, 64'h1234, 1'b0, 64'h4321);
		check_level("rs_full", rs_full, 1'b1);             // all entries occupied
		wait_drain();
		check_level("rs_full", rs_full, 1'b0);
		for (i = 0; i < 200; i++) begin                    // mixed random stream
			alloc_tag(dest);
			a_dep = (hist_cnt > 0) && ({$random(seed)} % 3 == 0);
			b_dep = (hist_cnt > 0) && ({$random(seed)} % 5 == 0);
			prev = (hist_cnt > 0) ? recent[{$random(seed)} % (hist_cnt < 8 ? hist_cnt : 8)] : '0;
			dispatch_op(rand_func(6), dest, a_dep, a_dep ? data_t'(prev) : rand_data(),
				b_dep, b_dep ? data_t'(recent[0]) : rand_data());
			recent[hist_cnt % 8] = dest;
			hist_cnt++;
			if ({$random(seed)} % 4 == 0)
				@(negedge clock);                          // idle gap
		end
		wait_drain();
		$display("TEST PASSED");
		$finish;
	end

endmodule

// ==== ooo_core.f ====
ooo_pkg.sv
rs.sv
alu_unit.sv
mult_unit.sv
cdb_arbiter.sv
ooo_core.sv
tb_ooo_core.sv

// ==== Makefile ====
VERILATOR = verilator
VFLAGS    = --binary --timing --assert
TOP       = tb_ooo_core
FLIST     = ooo_core.f
OBJ_DIR   = obj_dir

.PHONY: sim clean

sim:
	$(VERILATOR) $(VFLAGS) --top-module $(TOP) -f $(FLIST) --Mdir $(OBJ_DIR)
	./$(OBJ_DIR)/V$(TOP)

clean:
	rm -rf $(OBJ_DIR)
